// File: hw/ll_pkg.sv
/*
  Shared sizes and packed types for the AXI-Stream logic link transmitter.
  Every RTL block pulls these in with a wildcard import in its header.
  The PHY word layout here is the single source for bit positions,
  including the credit return bit read back from the receive lane.
*/

package ll_pkg;

  ////////////////////
  // User stream sizes
  localparam int DATA_W      = 64;
  localparam int KEEP_W      = 8;
  localparam int ST_BEAT_W   = 1 + KEEP_W + DATA_W;

  // PHY lane
  localparam int PHY_W       = 80;
  // Spare bits pad the word out to PHY_W
  localparam int PHY_SPARE_W = PHY_W - ST_BEAT_W - 4;

  ////////////////////
  // Buffering and flow control
  localparam int FIFO_DEPTH  = 4;
  localparam int PTR_W       = $clog2(FIFO_DEPTH);
  // One extra state so a full FIFO is distinct from empty
  localparam int CNT_W       = $clog2(FIFO_DEPTH + 1);
  localparam int CRED_W      = 8;

  // Auto-sync programmable delays
  localparam int DELAY_W     = 16;

  // Debug status word
  localparam int DBG_W       = 32;
  localparam int DBG_OCC_W   = 4;

  // One AXI-Stream beat as carried over the link
  typedef struct packed {
    logic              tlast;
    logic [KEEP_W-1:0] tkeep;
    logic [DATA_W-1:0] tdata;
  } st_beat_t;

  // Transmit PHY word, most significant field first
  typedef struct packed {
    logic [PHY_SPARE_W-1:0] spare;
    logic                   credit_ret;
    st_beat_t               payload;
    logic                   push;
    logic                   marker;
    logic                   strobe;
  } phy_word_t;

  // Debug status, unused low bits read as zero
  typedef struct packed {
    logic [CRED_W-1:0]                      credits;
    logic [DBG_OCC_W-1:0]                   occupancy;
    logic [1:0]                             online;
    logic [DBG_W-CRED_W-DBG_OCC_W-3:0]      rsvd;
  } tx_debug_t;

endpackage

// File: hw/ll_auto_sync.sv
/*
  Link bring-up helper for the transmitter.
  Delays the tx and rx online indications by programmable cycle counts
  and generates the periodic strobe user bit while the transmit side is
  online. A zero strobe period turns the strobe off.
*/

`timescale 1ns/1ns

module ll_auto_sync import ll_pkg::*; (
  input  logic               clk_wr,
  input  logic               arst_n,
  input  logic               tx_online,
  input  logic               rx_online,
  input  logic [DELAY_W-1:0] delay_x_value,
  input  logic [DELAY_W-1:0] delay_y_value,
  input  logic [DELAY_W-1:0] delay_z_value,
  output logic               tx_online_delay,
  output logic               rx_online_delay,
  output logic               tx_stb_userbit
);

  // Index 0 is transmit, index 1 is receive
  logic [1:0]         online_in;
  logic [1:0]         online_q;
  logic [DELAY_W-1:0] dly_limit [2];
  logic [DELAY_W-1:0] dly_cnt   [2];
  logic [DELAY_W-1:0] stb_cnt;

  assign online_in    = {rx_online, tx_online};
  assign dly_limit[0] = delay_x_value;
  assign dly_limit[1] = delay_y_value;

  ////////////////////
  // Online delay counters
  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      online_q <= '0;
      for (int i = 0; i < 2; i++) begin
        dly_cnt[i] <= '0;
      end
    end else begin
      for (int i = 0; i < 2; i++) begin
        if (!online_in[i]) begin
          // Drop straight away, restart the count
          dly_cnt[i]  <= '0;
          online_q[i] <= 1'b0;
        end else begin
          // Count equals cycles already seen online
          online_q[i] <= (dly_cnt[i] >= dly_limit[i]);
          if (dly_cnt[i] < dly_limit[i]) begin
            dly_cnt[i] <= dly_cnt[i] + 1'b1;
          end
        end
      end
    end
  end

  assign tx_online_delay = online_q[0];
  assign rx_online_delay = online_q[1];

  ////////////////////
  // Strobe period counter
  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      stb_cnt <= '0;
    end else if (!online_q[0] || (stb_cnt == delay_z_value - 1'b1)) begin
      stb_cnt <= '0;
    end else begin
      stb_cnt <= stb_cnt + 1'b1;
    end
  end

  // Phase zero of each period, first one on the first online cycle
  assign tx_stb_userbit = online_q[0] && (delay_z_value != '0) && (stb_cnt == '0);

endmodule

// File: hw/st_ingress.sv
/*
  User-facing AXI-Stream input stage.
  A single registered skid entry accepts tdata/tkeep/tlast beats, packs
  them into the link payload and holds each one until the transmit
  block takes it. Ready towards the user is enabled one clock after reset.
*/

`timescale 1ns/1ns

module st_ingress import ll_pkg::*; (
  input  logic              clk_wr,
  input  logic              arst_n,
  input  logic [DATA_W-1:0] user_tdata,
  input  logic [KEEP_W-1:0] user_tkeep,
  input  logic              user_tlast,
  input  logic              user_tvalid,
  output logic              user_tready,
  output logic              user_st_vld,
  output st_beat_t          user_st_data,
  input  logic              user_st_ready
);

  logic ready_en;
  logic beat_acc;

  // Room when empty, or when the held beat leaves this cycle
  assign user_tready = ready_en && (!user_st_vld || user_st_ready);
  assign beat_acc    = user_tvalid && user_tready;

  ////////////////////
  // Entry state
  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      ready_en    <= 1'b0;
      user_st_vld <= 1'b0;
    end else begin
      ready_en <= 1'b1;
      if (beat_acc) begin
        user_st_vld <= 1'b1;
      end else if (user_st_ready) begin
        user_st_vld <= 1'b0;
      end
    end
  end

  // Payload capture
  always_ff @(posedge clk_wr) begin
    if (beat_acc) begin
      user_st_data.tlast <= user_tlast;
      user_st_data.tkeep <= user_tkeep;
      user_st_data.tdata <= user_tdata;
    end
  end

endmodule

// File: hw/ll_fifo.sv
/*
  Small circular payload FIFO for the transmit path.
  Read data is shown from the head entry with no extra cycle, a write
  makes the FIFO non-empty on the next clock. Full, empty and the
  occupancy count drive flow control and debug status.
*/

`timescale 1ns/1ns

module ll_fifo import ll_pkg::*; (
  input  logic             clk_wr,
  input  logic             arst_n,
  input  logic             wr_en,
  input  st_beat_t         wr_data,
  input  logic             rd_en,
  output st_beat_t         rd_data,
  output logic             full,
  output logic             empty,
  output logic [CNT_W-1:0] count
);

  st_beat_t         mem [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic             wr_fire;
  logic             rd_fire;

  // Wrap at depth, not only at a power of two
  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  // Overflow and underflow requests are ignored
  assign wr_fire = wr_en && !full;
  assign rd_fire = rd_en && !empty;

  ////////////////////
  // Storage
  always_ff @(posedge clk_wr) begin
    if (wr_fire) begin
      mem[wr_ptr] <= wr_data;
    end
  end

  assign rd_data = mem[rd_ptr];

  // Pointers and occupancy
  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_fire) begin
        wr_ptr <= ptr_next(wr_ptr);
      end
      if (rd_fire) begin
        rd_ptr <= ptr_next(rd_ptr);
      end
      case ({wr_fire, rd_fire})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  assign full  = (count == CNT_W'(FIFO_DEPTH));
  assign empty = (count == '0);

endmodule

// File: hw/ll_transmit.sv
/*
  Logic link transmit core.
  Buffers user payloads in the FIFO and pops one per cycle while both
  delayed online flags are up and a credit is available. The credit
  count is reloaded on each link-up, drops on a push and rises on each
  returned credit. Push bit and payload leave through a register.
*/

`timescale 1ns/1ns

module ll_transmit import ll_pkg::*; (
  input  logic              clk_wr,
  input  logic              arst_n,
  input  logic              tx_online,
  input  logic              rx_online,
  input  logic [CRED_W-1:0] init_credit,
  input  logic              rx_credit,
  input  logic              user_valid,
  input  st_beat_t          user_data,
  output logic              user_ready,
  output logic              tx_pushbit,
  output st_beat_t          tx_data,
  output tx_debug_t         tx_debug_status
);

  logic              link_online;
  logic              link_online_q;
  logic              link_up;
  logic              fifo_full;
  logic              fifo_empty;
  logic [CNT_W-1:0]  fifo_count;
  st_beat_t          fifo_rd_data;
  logic              pop;
  logic [CRED_W-1:0] credit;

  ////////////////////
  // Link state
  assign link_online = tx_online && rx_online;
  assign link_up     = link_online && !link_online_q;

  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      link_online_q <= 1'b0;
    end else begin
      link_online_q <= link_online;
    end
  end

  // Payload buffer
  assign user_ready = !fifo_full;

  ll_fifo u_fifo (
    .clk_wr  (clk_wr),
    .arst_n  (arst_n),
    .wr_en   (user_valid && user_ready),
    .wr_data (user_data),
    .rd_en   (pop),
    .rd_data (fifo_rd_data),
    .full    (fifo_full),
    .empty   (fifo_empty),
    .count   (fifo_count)
  );

  ////////////////////
  // Pop decision
  // No pop on the link-up cycle, the count is stale until reloaded
  assign pop = link_online && link_online_q && !fifo_empty && (credit != '0);

  // Credit counter
  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      credit <= '0;
    end else if (link_up) begin
      // Returns on this cycle are dropped
      credit <= init_credit;
    end else begin
      credit <= credit - CRED_W'(pop) + CRED_W'(rx_credit);
    end
  end

  // Push register towards the PHY
  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      tx_pushbit <= 1'b0;
    end else begin
      tx_pushbit <= pop;
    end
  end

  always_ff @(posedge clk_wr) begin
    if (pop) begin
      tx_data <= fifo_rd_data;
    end
  end

  // Debug status
  always_comb begin
    tx_debug_status           = '0;
    tx_debug_status.credits   = credit;
    tx_debug_status.occupancy = DBG_OCC_W'(fifo_count);
    tx_debug_status.online    = {tx_online, rx_online};
  end

endmodule

// File: hw/phy_concat.sv
/*
  PHY side of the transmitter.
  Builds the 80-bit transmit word from payload, push and strobe bits and
  registers it onto the lane, zeroed while the link is offline. The
  returned credit bit is picked out of the receive word and registered.
*/

`timescale 1ns/1ns

module phy_concat import ll_pkg::*; (
  input  logic             clk_wr,
  input  logic             arst_n,
  input  logic             tx_online,
  input  st_beat_t         tx_st_data,
  input  logic             tx_st_pushbit,
  input  logic             tx_stb_userbit,
  output logic [PHY_W-1:0] tx_phy0,
  input  logic [PHY_W-1:0] rx_phy0,
  output logic             rx_st_credit
);

  phy_word_t tx_word;
  phy_word_t tx_word_q;
  phy_word_t rx_word;

  ////////////////////
  // Transmit word
  always_comb begin
    tx_word            = '0;
    // Credit return travels the other way only
    tx_word.credit_ret = 1'b0;
    tx_word.payload    = tx_st_data;
    tx_word.push       = tx_st_pushbit;
    // No user marker
    tx_word.marker     = 1'b0;
    tx_word.strobe     = tx_stb_userbit;
  end

  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      tx_word_q <= '0;
    end else if (tx_online) begin
      tx_word_q <= tx_word;
    end else begin
      // Quiet lane while offline
      tx_word_q <= '0;
    end
  end

  assign tx_phy0 = tx_word_q;

  ////////////////////
  // Credit return
  assign rx_word = rx_phy0;

  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      rx_st_credit <= 1'b0;
    end else begin
      rx_st_credit <= rx_word.credit_ret;
    end
  end

endmodule

// File: hw/axi_st_d64_master_top.sv
/*
  Top level of the 64-bit AXI-Stream transmit link.
  User beats enter through the ingress stage, are buffered and
  credit-gated by the transmit core and leave as one 80-bit PHY word per
  clock. The auto-sync block gates bring-up and marks strobe words.
*/

`timescale 1ns/1ns

module axi_st_d64_master_top import ll_pkg::*; (
  input  logic               clk_wr,
  input  logic               arst_n,
  // Link control
  input  logic               tx_online,
  input  logic               rx_online,
  input  logic [CRED_W-1:0]  init_st_credit,
  // PHY lane
  output logic [PHY_W-1:0]   tx_phy0,
  input  logic [PHY_W-1:0]   rx_phy0,
  // User stream
  input  logic [KEEP_W-1:0]  user_tkeep,
  input  logic [DATA_W-1:0]  user_tdata,
  input  logic               user_tlast,
  input  logic               user_tvalid,
  output logic               user_tready,
  // Status
  output tx_debug_t          tx_st_debug_status,
  // Bring-up delays and strobe period
  input  logic [DELAY_W-1:0] delay_x_value,
  input  logic [DELAY_W-1:0] delay_y_value,
  input  logic [DELAY_W-1:0] delay_z_value
);

  ////////////////////
  // Interconnect
  logic     user_st_vld;
  logic     user_st_ready;
  st_beat_t user_st_data;
  st_beat_t tx_st_data;
  logic     tx_st_pushbit;
  logic     rx_st_credit;
  logic     tx_online_delay;
  logic     rx_online_delay;
  logic     tx_stb_userbit;

  ll_auto_sync u_auto_sync (
    .clk_wr          (clk_wr),
    .arst_n          (arst_n),
    .tx_online       (tx_online),
    .rx_online       (rx_online),
    .delay_x_value   (delay_x_value),
    .delay_y_value   (delay_y_value),
    .delay_z_value   (delay_z_value),
    .tx_online_delay (tx_online_delay),
    .rx_online_delay (rx_online_delay),
    .tx_stb_userbit  (tx_stb_userbit)
  );

  st_ingress u_ingress (
    .clk_wr        (clk_wr),
    .arst_n        (arst_n),
    .user_tdata    (user_tdata),
    .user_tkeep    (user_tkeep),
    .user_tlast    (user_tlast),
    .user_tvalid   (user_tvalid),
    .user_tready   (user_tready),
    .user_st_vld   (user_st_vld),
    .user_st_data  (user_st_data),
    .user_st_ready (user_st_ready)
  );

  // Core sees only the delayed online flags
  ll_transmit u_transmit (
    .clk_wr          (clk_wr),
    .arst_n          (arst_n),
    .tx_online       (tx_online_delay),
    .rx_online       (rx_online_delay),
    .init_credit     (init_st_credit),
    .rx_credit       (rx_st_credit),
    .user_valid      (user_st_vld),
    .user_data       (user_st_data),
    .user_ready      (user_st_ready),
    .tx_pushbit      (tx_st_pushbit),
    .tx_data         (tx_st_data),
    .tx_debug_status (tx_st_debug_status)
  );

  phy_concat u_concat (
    .clk_wr         (clk_wr),
    .arst_n         (arst_n),
    .tx_online      (tx_online_delay),
    .tx_st_data     (tx_st_data),
    .tx_st_pushbit  (tx_st_pushbit),
    .tx_stb_userbit (tx_stb_userbit),
    .tx_phy0        (tx_phy0),
    .rx_phy0        (rx_phy0),
    .rx_st_credit   (rx_st_credit)
  );

endmodule

// File: dv/tb_model.svh
/*
  Reference model for the link transmitter testbench.
  Packs a user beat the way it should show up on the lane and predicts
  which PHY words are online, carry the strobe, or may carry a push,
  and which delayed online flags the debug status should show.
  Included inside the testbench module.
*/

`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// Lane bit positions, strobe at bit 0
localparam int STROBE_BIT  = 0;
localparam int MARKER_BIT  = 1;
localparam int PUSH_BIT    = 2;
localparam int PAYLOAD_LSB = 3;
localparam int PAYLOAD_MSB = 75;
localparam int CREDIT_BIT  = 76;

// tlast on top, then tkeep, then tdata
function automatic logic [72:0] pack_beat(input logic last, input logic [7:0] keep,
                                          input logic [63:0] data);
  return {last, keep, data};
endfunction

// since_prev counts clocks that saw tx_online high, up to the clock before the word
function automatic bit online_word(input int since_prev, input int dx);
  return since_prev >= dx + 1;
endfunction

// Delayed flag after the clock that sampled seen, since_prev counts the clocks before it
function automatic bit online_flag(input bit seen, input int since_prev, input int d);
  return seen && (since_prev >= d);
endfunction

// One strobe per period, first on the first online word
function automatic bit strobe_word(input int since_prev, input int dx, input int dz);
  if (dz == 0 || !online_word(since_prev, dx)) begin
    return 1'b0;
  end
  return ((since_prev - dx - 1) % dz) == 0;
endfunction

// Both delays, then the push register and the lane register
function automatic bit push_allowed(input int tx_prev, input int rx_prev,
                                    input int dx, input int dy);
  return (tx_prev >= dx + 2) && (rx_prev >= dy + 2);
endfunction

`endif

// File: dv/tb_top.sv
/*
  Testbench for the 64-bit AXI-Stream link transmitter.
  Offers random beats, plays the far side that returns credits, and
  checks every lane word against the reference model. Covers link-up
  delays, strobe period, credit stalls and a link drop with reload.
*/

`timescale 1ns/1ns

module tb_top import ll_pkg::*; ();

  localparam int NUM_BEATS       = 200;
  localparam int DELAY_X         = 5;
  localparam int DELAY_Y         = 7;
  localparam int DELAY_Z         = 10;
  localparam int INIT_CREDIT     = 3;
  localparam int RESET_CYCLES    = 16;
  localparam int WATCHDOG_CYCLES = NUM_BEATS * 20 + 2000;

  logic               clk_wr = 1'b0;
  logic               arst_n;
  logic               tx_online;
  logic               rx_online;
  logic [CRED_W-1:0]  init_st_credit;
  logic [PHY_W-1:0]   tx_phy0;
  logic [PHY_W-1:0]   rx_phy0 = '0;
  logic [KEEP_W-1:0]  user_tkeep = '0;
  logic [DATA_W-1:0]  user_tdata = '0;
  logic               user_tlast = 1'b0;
  logic               user_tvalid = 1'b0;
  logic               user_tready;
  tx_debug_t          tx_st_debug_status;
  logic [DELAY_W-1:0] delay_x_value;
  logic [DELAY_W-1:0] delay_y_value;
  logic [DELAY_W-1:0] delay_z_value;

  // Scoreboard and far-side state
  logic [72:0] exp_q [$];
  int          due_q [$];
  int          cycle_n = 0;
  int          accepted_n = 0;
  int          issued_n = 0;
  int          delivered_n = 0;
  int          check_n = 0;
  int          error_n = 0;
  int          pushes_since_up = 0;
  int          returns_since_up = 0;
  int          tx_since = 0;
  int          rx_since = 0;
  bit          tx_seen = 1'b0;
  bit          rx_seen = 1'b0;
  bit          accept_now = 1'b0;
  bit          withhold = 1'b0;
  bit          stim_en = 1'b0;

  `include "tb_model.svh"

  always #50 clk_wr = ~clk_wr;

  axi_st_d64_master_top UUT (
    .clk_wr             (clk_wr),
    .arst_n             (arst_n),
    .tx_online          (tx_online),
    .rx_online          (rx_online),
    .init_st_credit     (init_st_credit),
    .tx_phy0            (tx_phy0),
    .rx_phy0            (rx_phy0),
    .user_tkeep         (user_tkeep),
    .user_tdata         (user_tdata),
    .user_tlast         (user_tlast),
    .user_tvalid        (user_tvalid),
    .user_tready        (user_tready),
    .tx_st_debug_status (tx_st_debug_status),
    .delay_x_value      (delay_x_value),
    .delay_y_value      (delay_y_value),
    .delay_z_value      (delay_z_value)
  );

  ////////////////////
  // Checking helpers
  task automatic check_value(input string name, input logic [79:0] actual,
                             input logic [79:0] expected);
    check_n++;
    if (actual !== expected) begin
      error_n++;
      $display("FAILED at %0t: %s is %h, expected %h", $time, name, actual, expected);
    end
  endtask

  task automatic report_problem(input string msg);
    error_n++;
    $display("ERROR at %0t: %s", $time, msg);
  endtask

  task automatic print_summary();
    $display("Summary: %0d checks, %0d errors, %0d of %0d beats accepted, %0d delivered",
             check_n, error_n, accepted_n, NUM_BEATS, delivered_n);
  endtask

  // Stall needs skid and FIFO both full
  task automatic wait_tready_low(input int max_cycles);
    int n;
    n = 0;
    @(negedge clk_wr);
    while (user_tready !== 1'b0 && n < max_cycles) begin
      @(negedge clk_wr);
      n++;
    end
    if (user_tready !== 1'b0) begin
      report_problem("user_tready never fell while credits were withheld");
    end
  endtask

  // Pushed word against the oldest accepted beat
  task automatic take_push(input logic [79:0] word);
    check_value("tx_phy0.push allowed",
                80'(push_allowed(tx_since, rx_since, DELAY_X, DELAY_Y)), 80'd1);
    pushes_since_up++;
    due_q.push_back(cycle_n + int'($urandom_range(7, 0)));
    if (exp_q.size() == 0) begin
      report_problem("tx_phy0 pushed a beat that was never accepted");
    end else begin
      check_value("tx_phy0.payload", 80'(word[PAYLOAD_MSB:PAYLOAD_LSB]), 80'(exp_q.pop_front()));
      delivered_n++;
    end
  endtask

  ////////////////////
  // User stimulus, valid held until the beat is taken
  always @(posedge clk_wr) begin
    if (stim_en && (!user_tvalid || accept_now)) begin
      if (issued_n < NUM_BEATS && $urandom_range(3, 0) != 0) begin
        user_tdata  <= {$urandom, $urandom};
        user_tkeep  <= KEEP_W'($urandom);
        user_tlast  <= ($urandom_range(7, 0) == 0);
        user_tvalid <= 1'b1;
        issued_n++;
      end else begin
        user_tvalid <= 1'b0;
      end
    end
  end

  // Far side, one credit back per cycle once due
  always @(posedge clk_wr) begin : credit_return
    int idx;
    idx = -1;
    if (!withhold) begin
      foreach (due_q[i]) begin
        if (idx < 0 && due_q[i] <= cycle_n) begin
          idx = i;
        end
      end
    end
    if (idx >= 0) begin
      due_q.delete(idx);
      returns_since_up++;
    end
    rx_phy0 <= (idx >= 0) ? (80'd1 << CREDIT_BIT) : '0;
  end

  // Lane monitor, sampled mid-cycle
  always @(negedge clk_wr) begin : lane_monitor
    logic [79:0] word;
    cycle_n++;
    // Handshake seen here completes on the next rising edge
    accept_now = user_tvalid && user_tready;
    if (accept_now) begin
      exp_q.push_back(pack_beat(user_tlast, user_tkeep, user_tdata));
      accepted_n++;
    end
    word = tx_phy0;
    if (!online_word(tx_since, DELAY_X)) begin
      check_value("tx_phy0", word, '0);
    end else begin
      check_value("tx_phy0.strobe", 80'(word[STROBE_BIT]),
                  80'(strobe_word(tx_since, DELAY_X, DELAY_Z)));
      check_value("tx_phy0.marker", 80'(word[MARKER_BIT]), 80'd0);
      check_value("tx_phy0 spare bits", 80'(word[79:CREDIT_BIT]), 80'd0);
      if (word[PUSH_BIT]) begin
        take_push(word);
      end
    end
    check_value("credits in flight within limit",
                80'((pushes_since_up - returns_since_up) <= INIT_CREDIT), 80'd1);
    // Debug status flags as of the last clock
    check_value("tx_st_debug_status.online", 80'(tx_st_debug_status.online),
                80'({online_flag(tx_seen, tx_since, DELAY_X),
                     online_flag(rx_seen, rx_since, DELAY_Y)}));
    check_value("tx_st_debug_status.rsvd", 80'(tx_st_debug_status.rsvd), 80'd0);
    // Online history as the DUT sampled it
    tx_since = tx_seen ? tx_since + 1 : 0;
    rx_since = rx_seen ? rx_since + 1 : 0;
    tx_seen  = tx_online;
    rx_seen  = rx_online;
  end

  ////////////////////
  // Test sequence
  initial begin : sequence_main
    int n;
    void'($urandom(32'h50));
    arst_n         = 1'b0;
    tx_online      = 1'b0;
    rx_online      = 1'b0;
    init_st_credit = CRED_W'(INIT_CREDIT);
    delay_x_value  = DELAY_W'(DELAY_X);
    delay_y_value  = DELAY_W'(DELAY_Y);
    delay_z_value  = DELAY_W'(DELAY_Z);
    repeat (RESET_CYCLES) @(posedge clk_wr);
    arst_n <= 1'b1;
    repeat (4) @(posedge clk_wr);
    // Both sides come up together
    tx_online <= 1'b1;
    rx_online <= 1'b1;
    stim_en   <= 1'b1;
    while (accepted_n < 50) @(posedge clk_wr);
    // First credit stall, then resume
    withhold <= 1'b1;
    wait_tready_low(200);
    repeat (10) @(posedge clk_wr);
    withhold <= 1'b0;
    while (accepted_n < 120) @(posedge clk_wr);
    // Second stall, drained credits, then link drop
    withhold <= 1'b1;
    wait_tready_low(200);
    repeat (10) @(posedge clk_wr);
    wait_tready_low(50);
    // Every credit spent, FIFO holding the stalled beats
    check_value("tx_st_debug_status.credits", 80'(tx_st_debug_status.credits), 80'd0);
    check_value("tx_st_debug_status.occupancy", 80'(tx_st_debug_status.occupancy),
                80'(FIFO_DEPTH));
    @(posedge clk_wr);
    tx_online <= 1'b0;
    due_q.delete();
    repeat (12) @(posedge clk_wr);
    pushes_since_up  <= 0;
    returns_since_up <= 0;
    tx_online        <= 1'b1;
    // Returns still held, only the reloaded credits go out
    n = 0;
    while (pushes_since_up < INIT_CREDIT && n < 100) begin
      @(posedge clk_wr);
      n++;
    end
    repeat (20) @(posedge clk_wr);
    check_value("pushes after reload", 80'(pushes_since_up), 80'(INIT_CREDIT));
    withhold <= 1'b0;
    while (delivered_n < NUM_BEATS) @(posedge clk_wr);
    // Catch any extra beat, let the last credits come home
    repeat (30) @(posedge clk_wr);
    @(negedge clk_wr);
    check_value("tx_st_debug_status.credits", 80'(tx_st_debug_status.credits),
                80'(INIT_CREDIT));
    check_value("tx_st_debug_status.occupancy", 80'(tx_st_debug_status.occupancy), 80'd0);
    print_summary();
    if (error_n == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  // Watchdog
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_wr);
    $display("Watchdog expired after %0d cycles, run did not complete", WATCHDOG_CYCLES);
    print_summary();
    $display(">>> FAIL");
    $finish;
  end

endmodule

// File: tb.f
+incdir+dv
hw/ll_pkg.sv
hw/ll_auto_sync.sv
hw/st_ingress.sv
hw/ll_fifo.sv
hw/ll_transmit.sv
hw/phy_concat.sv
hw/axi_st_d64_master_top.sv
dv/tb_top.sv

// File: run.sh
#!/bin/sh
# Build and run the transmitter testbench with Verilator
set -e
verilator --binary --timing -Wno-fatal --top-module tb_top -f tb.f -o Vtb_top
out=$(./obj_dir/Vtb_top)
echo "$out"
if echo "$out" | grep -q '^>>> PASS$'; then
  exit 0
fi
exit 1
